//--- design/digitalPll.sv
`timescale 1ns/1ps
`default_nettype none

module digitalPll import pllPkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  busWriteT          busWr,
    input  logic [ADDR_W-1:0] rdAddr,
    output logic [DATA_W-1:0] dataOut,
    input  logic              referenceClkEn,
    output logic              ncoClk,
    output logic              filteredRefClk,
    output logic [ERR_W-1:0]  phaseError
);

    pllConfigT         cfg;
    logic [FREQ_W-1:0] phaseInc;
    logic              vcoWrap;
    logic              feedbackClkEn;

    // Bus-side configuration
    pllRegs regs (
        .clk     (clk),
        .reset   (reset),
        .busWr   (busWr),
        .rdAddr  (rdAddr),
        .dataOut (dataOut),
        .cfg     (cfg)
    );

    ncoCore nco (
        .clk      (clk),
        .reset    (reset),
        .phaseInc (phaseInc),
        .ncoClk   (ncoClk),
        .vcoWrap  (vcoWrap)
    );

    // Wraps become feedback pulses and the divided clock
    pllDivider divider (
        .clk            (clk),
        .reset          (reset),
        .cfg            (cfg),
        .vcoWrap        (vcoWrap),
        .ncoClk         (ncoClk),
        .feedbackClkEn  (feedbackClkEn),
        .filteredRefClk (filteredRefClk)
    );

    // Comparator and proportional filter close the loop
    loopFilter filter (
        .clk            (clk),
        .reset          (reset),
        .cfg            (cfg),
        .referenceClkEn (referenceClkEn),
        .feedbackClkEn  (feedbackClkEn),
        .phaseError     (phaseError),
        .phaseInc       (phaseInc)
    );

endmodule

`default_nettype wire

//--- design/loopFilter.sv
`timescale 1ns/1ps
`default_nettype none

module loopFilter import pllPkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  pllConfigT         cfg,
    input  logic              referenceClkEn,
    input  logic              feedbackClkEn,
    output logic [ERR_W-1:0]  phaseError,
    output logic [FREQ_W-1:0] phaseInc
);

    logic signed [FREQ_W-1:0] errExt;
    logic signed [FREQ_W-1:0] shifted;
    logic signed [FREQ_W-1:0] leadError;
    logic        [FREQ_W-1:0] errorSum;

    // Phase comparator, wraps at 8 bits
    always_ff @(posedge clk) begin
        if (reset) begin
            phaseError <= '0;
        end else if (referenceClkEn && !feedbackClkEn) begin
            phaseError <= phaseError - 1'b1;
        end else if (feedbackClkEn && !referenceClkEn) begin
            phaseError <= phaseError + 1'b1;
        end
    end

    assign errExt = {{(FREQ_W-ERR_W){phaseError[ERR_W-1]}}, phaseError};

    // Gain 7 passes the error through; each step doubles or halves it
    always_comb begin
        if (cfg.loopGain == '0) begin
            shifted = '0;
        end else if (cfg.loopGain >= UNITY_GAIN) begin
            shifted = errExt <<< (cfg.loopGain - UNITY_GAIN);
        end else begin
            shifted = errExt >>> (UNITY_GAIN - cfg.loopGain);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            leadError <= '0;
        end else begin
            leadError <= shifted;
        end
    end

    assign errorSum = cfg.centerFreq + leadError;

    // Saturate on the sum's MSB, direction from the error sign
    always_ff @(posedge clk) begin
        if (reset) begin
            phaseInc <= '0;
        end else if (errorSum[FREQ_W-1] && !leadError[FREQ_W-1]) begin
            phaseInc <= INC_MAX;
        end else if (errorSum[FREQ_W-1] && leadError[FREQ_W-1]) begin
            phaseInc <= '0;
        end else begin
            phaseInc <= errorSum;
        end
    end

endmodule

`default_nettype wire

//--- design/ncoCore.sv
`timescale 1ns/1ps
`default_nettype none

module ncoCore import pllPkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [FREQ_W-1:0] phaseInc,
    output logic              ncoClk,
    output logic              vcoWrap
);

    logic [FREQ_W-1:0] phase;
    logic [FREQ_W-1:0] phaseSum;
    logic [1:0]        msbHist;

    assign phaseSum = phase + phaseInc;

    // Accumulator plus two-bit MSB history
    always_ff @(posedge clk) begin
        if (reset) begin
            phase   <= '0;
            msbHist <= 2'b00;
        end else begin
            phase   <= phaseSum;
            msbHist <= {msbHist[0], phaseSum[FREQ_W-1]};
        end
    end

    // Falling MSB marks an overflow
    always_ff @(posedge clk) begin
        if (reset) begin
            vcoWrap <= 1'b0;
        end else begin
            vcoWrap <= (msbHist == 2'b10);
        end
    end

    // Output level lags the MSB by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            ncoClk <= 1'b0;
        end else begin
            ncoClk <= phase[FREQ_W-1];
        end
    end

endmodule

`default_nettype wire

//--- design/pllDivider.sv
`timescale 1ns/1ps
`default_nettype none

module pllDivider import pllPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  pllConfigT cfg,
    input  logic      vcoWrap,
    input  logic      ncoClk,
    output logic      feedbackClkEn,
    output logic      filteredRefClk
);

    logic [DIV_W-1:0] fbCount;
    logic [DIV_W-1:0] fbReload;

    logic [DIV_W-2:0] halfDiv;
    logic [DIV_W-2:0] outCount;
    logic [DIV_W-2:0] outReload;
    logic             ncoClkDly;
    logic             ncoRise;
    logic             divClk;

    // Divider of 0 or 1 pulses on every wrap
    assign fbReload = (cfg.feedbackDivider <= 1) ? '0 : cfg.feedbackDivider - 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            fbCount       <= fbReload;
            feedbackClkEn <= 1'b0;
        end else begin
            feedbackClkEn <= vcoWrap && (fbCount == '0);
            if (vcoWrap) begin
                if (fbCount == '0) begin
                    fbCount <= fbReload;
                end else begin
                    fbCount <= fbCount - 1'b1;
                end
            end
        end
    end

    // Output divider counts ncoClk rising edges seen on clk
    assign halfDiv   = cfg.feedbackDivider[DIV_W-1:1];
    assign outReload = halfDiv - 1'b1;
    assign ncoRise   = ncoClk && !ncoClkDly;

    always_ff @(posedge clk) begin
        if (reset) begin
            ncoClkDly <= 1'b0;
        end else begin
            ncoClkDly <= ncoClk;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            outCount <= outReload;
            divClk   <= 1'b0;
        end else if (ncoRise) begin
            if (outCount == '0) begin
                outCount <= outReload;
                divClk   <= !divClk;
            end else begin
                outCount <= outCount - 1'b1;
            end
        end
    end

    // Bypass when the half divider is zero
    assign filteredRefClk = (halfDiv == '0) ? ncoClk : divClk;

endmodule

`default_nettype wire

//--- design/pllPkg.sv
`default_nettype none

package pllPkg;

    // Bus geometry
    localparam int ADDR_W   = 13;
    localparam int DATA_W   = 32;
    localparam int LANES    = DATA_W / 8;
    localparam int OFFSET_W = 4;

    // Bits above the offset field must match this base
    localparam logic [ADDR_W-1:0] PLL_BASE = 13'h0400;

    // Word offsets inside the region
    localparam logic [OFFSET_W-1:0] REG_CENTER_FREQ = 4'h0;
    localparam logic [OFFSET_W-1:0] REG_GAINS       = 4'h1;
    localparam logic [OFFSET_W-1:0] REG_OUTPUT_DIV  = 4'h2;

    // Byte lanes that carry the narrow fields
    localparam int GAIN_LANE = 0;
    localparam int DIV_LANE  = 2;

    // Loop field widths
    localparam int FREQ_W = 32;
    localparam int ERR_W  = 8;
    localparam int GAIN_W = 5;
    localparam int DIV_W  = 8;

    // Gain at which the error enters the sum unshifted
    localparam logic [GAIN_W-1:0] UNITY_GAIN = 5'd7;

    // Largest increment the adder may hand to the NCO
    localparam logic [FREQ_W-1:0] INC_MAX = 32'h7fff_ffff;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [LANES-1:0]  byteEn;
    } busWriteT;

    typedef struct packed {
        logic [FREQ_W-1:0] centerFreq;
        logic [GAIN_W-1:0] loopGain;
        logic [DIV_W-1:0]  feedbackDivider;
    } pllConfigT;

endpackage

`default_nettype wire

//--- design/pllRegs.sv
`timescale 1ns/1ps
`default_nettype none

module pllRegs import pllPkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  busWriteT          busWr,
    input  logic [ADDR_W-1:0] rdAddr,
    output logic [DATA_W-1:0] dataOut,
    output pllConfigT         cfg
);

    logic                wrInRegion;
    logic                rdInRegion;
    logic                wrAny;
    logic [OFFSET_W-1:0] wrOffset;
    logic [OFFSET_W-1:0] rdOffset;
    logic [DATA_W-1:0]   sharedWord;

    // Region match on the bits above the register offset
    assign wrInRegion = busWr.addr[ADDR_W-1:OFFSET_W] == PLL_BASE[ADDR_W-1:OFFSET_W];
    assign rdInRegion = rdAddr[ADDR_W-1:OFFSET_W] == PLL_BASE[ADDR_W-1:OFFSET_W];

    assign wrAny    = wrInRegion && (busWr.byteEn != '0);
    assign wrOffset = busWr.addr[OFFSET_W-1:0];
    assign rdOffset = rdAddr[OFFSET_W-1:0];

    // Gains and divider share one read word
    assign sharedWord = {8'h00, cfg.feedbackDivider, 11'h000, cfg.loopGain};

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg <= '0;
        end else if (wrAny) begin
            case (wrOffset)
                REG_CENTER_FREQ: begin
                    for (int lane = 0; lane < LANES; lane++) begin
                        if (busWr.byteEn[lane]) begin
                            cfg.centerFreq[8*lane +: 8] <= busWr.data[8*lane +: 8];
                        end
                    end
                end
                REG_GAINS: begin
                    if (busWr.byteEn[GAIN_LANE]) begin
                        cfg.loopGain <= busWr.data[8*GAIN_LANE +: GAIN_W];
                    end
                end
                REG_OUTPUT_DIV: begin
                    if (busWr.byteEn[DIV_LANE]) begin
                        cfg.feedbackDivider <= busWr.data[8*DIV_LANE +: DIV_W];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Read side, zero outside the region and on unmapped offsets
    always_comb begin
        dataOut = '0;
        if (rdInRegion) begin
            case (rdOffset)
                REG_CENTER_FREQ: dataOut = cfg.centerFreq;
                REG_GAINS:       dataOut = sharedWord;
                REG_OUTPUT_DIV:  dataOut = sharedWord;
                default:         dataOut = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- digitalPll.f
design/pllPkg.sv
design/pllRegs.sv
design/ncoCore.sv
design/pllDivider.sv
design/loopFilter.sv
design/digitalPll.sv
verif/digitalPllTb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run the testbench, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module digitalPllTb \
    -f digitalPll.f \
    -o digitalPllSim \
    && ./obj_dir/digitalPllSim > sim.log 2>&1 \
    || { echo "Build or simulation failed"; [ -f sim.log ] && cat sim.log; exit 1; }

cat sim.log

grep -qx "=== PASS ===" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- verif/digitalPllTb.sv
`timescale 1ns/1ps
`default_nettype none

module digitalPllTb import pllPkg::*; ();

    logic              clk;
    logic              reset;
    busWriteT          busWr;
    logic [ADDR_W-1:0] rdAddr;
    logic [DATA_W-1:0] dataOut;
    logic              referenceClkEn;
    logic              ncoClk;
    logic              filteredRefClk;
    logic [ERR_W-1:0]  phaseError;

    int errors;
    int timeouts;
    int refPeriod;
    int refCount;
    int riseExpect;

    // Expected register contents
    logic [31:0] centerModel;
    logic [4:0]  gainModel;
    logic [7:0]  divModel;

    // Check enables and their reference values
    logic        readActive;
    logic [31:0] expRead;
    logic        freqCheck;
    logic        divCheck;
    logic        bypassCheck;
    logic        noRefCheck;
    logic        refCheck;
    logic        riseCheck;
    logic        loopCheck;
    logic [7:0]  errStart;
    logic [7:0]  errBase;

    // Monitor state
    logic       ncoPrev;
    logic       divPrev;
    logic       fbPrev;
    int         ncoRun;
    int         divRun;
    logic [7:0] errPrev;
    logic [7:0] errStep;
    logic [7:0] riseDelta;
    logic [7:0] loopDelta;

    digitalPll UUT (
        .clk            (clk),
        .reset          (reset),
        .busWr          (busWr),
        .rdAddr         (rdAddr),
        .dataOut        (dataOut),
        .referenceClkEn (referenceClkEn),
        .ncoClk         (ncoClk),
        .filteredRefClk (filteredRefClk),
        .phaseError     (phaseError)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Reference pulse source, off while refPeriod is zero
    initial begin
        int period;
        referenceClkEn = 1'b0;
        refCount = 0;
        forever begin
            @(posedge clk);
            period = refPeriod;
            #1;
            if (period == 0) begin
                referenceClkEn = 1'b0;
                refCount = 0;
            end else begin
                referenceClkEn = (refCount == 0);
                refCount = (refCount + 1 >= period) ? 0 : refCount + 1;
            end
        end
    end

    // Run lengths and previous values for the checks below
    always @(posedge clk) begin
        if (reset) begin
            ncoPrev <= 1'b0;
            divPrev <= 1'b0;
            fbPrev  <= 1'b0;
            ncoRun  <= 0;
            divRun  <= 0;
            errPrev <= '0;
        end else begin
            ncoPrev <= ncoClk;
            divPrev <= filteredRefClk;
            fbPrev  <= UUT.feedbackClkEn;
            ncoRun  <= (ncoClk != ncoPrev) ? 1 : ncoRun + 1;
            divRun  <= (filteredRefClk != divPrev) ? 1 : divRun + 1;
            errPrev <= phaseError;
        end
    end

    assign errStep   = phaseError - errPrev;
    assign riseDelta = phaseError - errStart;
    assign loopDelta = phaseError - errBase;

    readBack: assert property (@(posedge clk) disable iff (reset)
        readActive |-> dataOut == expRead)
        else begin
            errors = errors + 1;
            $display("Mismatch dataOut at %h: got %h expected %h",
                $sampled(rdAddr), $sampled(dataOut), $sampled(expRead));
        end

    ncoHalfPeriod: assert property (@(posedge clk) disable iff (reset)
        freqCheck && ncoClk != ncoPrev |-> ncoRun == 8)
        else begin
            errors = errors + 1;
            $display("Mismatch ncoClk run length: got %h expected %h", $sampled(ncoRun), 8);
        end

    divHalfPeriod: assert property (@(posedge clk) disable iff (reset)
        divCheck && filteredRefClk != divPrev |-> divRun == 32)
        else begin
            errors = errors + 1;
            $display("Mismatch filteredRefClk run length: got %h expected %h",
                $sampled(divRun), 32);
        end

    divBypass: assert property (@(posedge clk) disable iff (reset)
        bypassCheck |-> filteredRefClk == ncoClk)
        else begin
            errors = errors + 1;
            $display("Mismatch filteredRefClk: got %h expected %h",
                $sampled(filteredRefClk), $sampled(ncoClk));
        end

    errNeverFalls: assert property (@(posedge clk) disable iff (reset)
        noRefCheck |-> (errStep == 8'h00 || errStep == 8'h01))
        else begin
            errors = errors + 1;
            $display("Mismatch phaseError: got %h after %h", $sampled(phaseError),
                $sampled(errPrev));
        end

    errNoRiseWithoutFb: assert property (@(posedge clk) disable iff (reset)
        refCheck && !fbPrev |-> (errStep == 8'h00 || errStep == 8'hff))
        else begin
            errors = errors + 1;
            $display("Mismatch phaseError: got %h after %h", $sampled(phaseError),
                $sampled(errPrev));
        end

    errRiseCount: assert property (@(posedge clk) disable iff (reset)
        riseCheck |-> (riseDelta >= riseExpect - 1 && riseDelta <= riseExpect + 1))
        else begin
            errors = errors + 1;
            $display("Mismatch phaseError rise: got %h expected %h",
                $sampled(riseDelta), riseExpect);
        end

    // Signed drift within 32 either way
    lockHold: assert property (@(posedge clk) disable iff (reset)
        loopCheck |-> (loopDelta <= 8'd32 || loopDelta >= 8'd224))
        else begin
            errors = errors + 1;
            $display("Mismatch phaseError: got %h base %h", $sampled(phaseError),
                $sampled(errBase));
        end

    function automatic logic [ADDR_W-1:0] regAddr(input logic [OFFSET_W-1:0] off);
        return {PLL_BASE[ADDR_W-1:OFFSET_W], off};
    endfunction

    function automatic logic [31:0] mergeLanes(input logic [31:0] old,
                                               input logic [31:0] data,
                                               input logic [3:0]  lanes);
        logic [31:0] result;
        result = old;
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) begin
                result[8*b +: 8] = data[8*b +: 8];
            end
        end
        return result;
    endfunction

    // Shared read word of the gains and divider registers
    function automatic logic [31:0] gainsWord();
        return {8'h00, divModel, 11'h000, gainModel};
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic cycles(input int n);
        repeat (n) begin
            nextCycle();
        end
    endtask

    task automatic writeReg(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                            input logic [3:0] lanes);
        busWr.addr   = addr;
        busWr.data   = data;
        busWr.byteEn = lanes;
        nextCycle();
        busWr.byteEn = '0;
    endtask

    task automatic readCheck(input logic [ADDR_W-1:0] addr, input logic [31:0] expected);
        rdAddr     = addr;
        expRead    = expected;
        readActive = 1'b1;
        nextCycle();
        readActive = 1'b0;
    endtask

    task automatic checkAllRegs();
        readCheck(regAddr(REG_CENTER_FREQ), centerModel);
        readCheck(regAddr(REG_GAINS), gainsWord());
        readCheck(regAddr(REG_OUTPUT_DIV), gainsWord());
    endtask

    task automatic waitNcoRise(input int limit);
        logic prev;
        int   waited;
        waited = 0;
        prev = ncoClk;
        nextCycle();
        while (!(ncoClk && !prev) && waited < limit) begin
            prev = ncoClk;
            nextCycle();
            waited++;
        end
        if (!(ncoClk && !prev)) begin
            timeouts++;
            $display("Timeout: ncoClk did not rise within %0d cycles", limit);
        end
    endtask

    task automatic waitDivToggle(input int limit);
        logic prev;
        int   waited;
        waited = 0;
        prev = filteredRefClk;
        nextCycle();
        while (filteredRefClk == prev && waited < limit) begin
            nextCycle();
            waited++;
        end
        if (filteredRefClk == prev) begin
            timeouts++;
            $display("Timeout: filteredRefClk did not toggle within %0d cycles", limit);
        end
    endtask

    task automatic waitErrorStep(input int limit);
        logic [7:0] startErr;
        int         waited;
        waited = 0;
        startErr = phaseError;
        nextCycle();
        while (phaseError == startErr && waited < limit) begin
            nextCycle();
            waited++;
        end
        if (phaseError == startErr) begin
            timeouts++;
            $display("Timeout: phaseError did not change within %0d cycles", limit);
        end
    endtask

    initial begin
        logic [31:0] data;
        logic [3:0]  lanes;
        logic [ADDR_W-1:0] outside [6];

        void'($urandom(32'hb479));
        outside = '{13'h0000, 13'h0001, 13'h0410, 13'h0c02, 13'h1400, 13'h1fff};
        errors = 0;
        timeouts = 0;
        refPeriod = 0;
        reset = 1'b1;
        busWr = '0;
        rdAddr = '0;
        expRead = '0;
        {readActive, freqCheck, divCheck, bypassCheck} = 4'b0000;
        {noRefCheck, refCheck, riseCheck, loopCheck} = 4'b0000;
        errStart = '0;
        errBase = '0;
        riseExpect = 0;
        centerModel = '0;
        gainModel = '0;
        divModel = '0;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;

        // Byte-lane writes and read-back
        for (int i = 0; i < 16; i++) begin
            data = $urandom;
            lanes = 4'($urandom);
            writeReg(regAddr(REG_CENTER_FREQ), data, lanes);
            centerModel = mergeLanes(centerModel, data, lanes);
            readCheck(regAddr(REG_CENTER_FREQ), centerModel);
        end
        for (int i = 0; i < 8; i++) begin
            data = $urandom;
            lanes = 4'($urandom);
            writeReg(regAddr(REG_GAINS), data, lanes);
            if (lanes[0]) begin
                gainModel = data[4:0];
            end
            checkAllRegs();
            data = $urandom;
            lanes = 4'($urandom);
            writeReg(regAddr(REG_OUTPUT_DIV), data, lanes);
            if (lanes[2]) begin
                divModel = data[23:16];
            end
            checkAllRegs();
        end

        // Unmapped and out-of-region accesses
        for (int off = 3; off < 16; off++) begin
            readCheck(regAddr(4'(off)), 32'h0);
            writeReg(regAddr(4'(off)), $urandom, 4'hf);
        end
        foreach (outside[k]) begin
            readCheck(outside[k], 32'h0);
            writeReg(outside[k], $urandom, 4'hf);
        end
        checkAllRegs();

        // Open loop at a 16-cycle NCO period
        writeReg(regAddr(REG_GAINS), 32'h0, 4'h1);
        gainModel = '0;
        writeReg(regAddr(REG_OUTPUT_DIV), 32'h0004_0000, 4'h4);
        divModel = 8'd4;
        writeReg(regAddr(REG_CENTER_FREQ), 32'h1000_0000, 4'hf);
        centerModel = 32'h1000_0000;
        checkAllRegs();
        waitNcoRise(64);
        nextCycle();
        freqCheck = 1'b1;
        cycles(160);
        freqCheck = 1'b0;

        // Old divider count drains first
        waitDivToggle(4096);
        nextCycle();
        divCheck = 1'b1;
        cycles(400);
        divCheck = 1'b0;

        // Feedback only, one step per 64 cycles
        waitErrorStep(8192);
        errStart = phaseError;
        riseExpect = 8;
        noRefCheck = 1'b1;
        cycles(512);
        riseCheck = 1'b1;
        nextCycle();
        riseCheck = 1'b0;
        noRefCheck = 1'b0;

        writeReg(regAddr(REG_OUTPUT_DIV), 32'h0001_0000, 4'h4);
        bypassCheck = 1'b1;
        cycles(100);
        bypassCheck = 1'b0;

        refPeriod = 8;
        refCheck = 1'b1;
        cycles(400);
        refCheck = 1'b0;

        // Closed loop with unity gain
        refPeriod = 64;
        writeReg(regAddr(REG_OUTPUT_DIV), 32'h0004_0000, 4'h4);
        writeReg(regAddr(REG_GAINS), 32'h7, 4'h1);
        cycles(500);
        errBase = phaseError;
        loopCheck = 1'b1;
        cycles(1500);
        loopCheck = 1'b0;
        refPeriod = 0;

        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
